// ==== bench/clkgen_input.txt ====
// op addr code expect, hex
// op 0 write, 1 read, 2 measure clock (addr 0 link, 1 core), 3 read burst, f end
1 0 0 08
1 1 0 08
1 2 0 00
2 0 0 08
2 1 0 08
0 0 1 00
2 0 1 01
0 0 2 00
2 0 2 02
0 0 3 00
2 0 3 03
0 0 4 00
2 0 4 04
0 0 5 00
2 0 5 05
0 0 6 00
2 0 6 06
0 0 7 00
2 0 7 06
0 1 0 00
2 1 0 00
0 1 c 00
2 1 c 08
3 0 7 0c
f 0 0 00

// ==== project.f ====
+incdir+design
design/clkgen_pkg.sv
design/credit_fifo.sv
design/clkgen_regs.sv
design/clock_divider.sv
design/clkgen_top.sv
bench/clkgen_assert.sv
bench/clkgen_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= clkgen_tb
RTL_TOP   ?= clkgen_top
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/clkgen_tb.sv ====
// Testbench for the link clock generator
// Vector driven register access, credit model and clock edge measurement
`timescale 1ns/1ps
`include "clkgen_config.svh"

module clkgen_tb;

  logic                 clkin = 1'b0;
  logic                 reset = 1'b1;
  logic                 cmd_valid = 1'b0;
  clkgen_pkg::cfg_cmd_t cmd = '0;
  logic                 cmd_credit;
  logic                 rsp_valid;
  clkgen_pkg::cfg_rsp_t rsp;
  logic                 rsp_credit = 1'b0;
  logic                 link_clk;
  logic                 link_clk90;
  logic                 core_clk;
  logic                 core_clk90;

  logic [7:0]           vec [0:255];          // op, addr, code, expect per line
  int                   host_crd = `CLKGEN_FIFO_DEPTH;
  int                   rsp_owed = 0;         // Credits still to hand back
  bit                   hold = 1'b0;          // Withhold response credits
  clkgen_pkg::cfg_rsp_t rsp_q [$];
  realtime              rise_t [4];           // link, link90, core, core90
  int                   rise_n [4] = '{0, 0, 0, 0};
  realtime              fall_t [2];
  int                   fall_n [2] = '{0, 0};
  realtime              glitch_min = 0.0;     // Shortest legal link high pulse
  clkgen_pkg::div_code_t cur_link = 4'd8;
  int                   cycles = 0;
  int                   limit = 0;

  clkgen_top i_clkgen_top (.*);

  always #5 clkin = ~clkin;

  // ##############################
  // Checks
  // ##############################
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_mismatch(input string msg);
    abort_run($sformatf("MISMATCH at %0t ns: %s", $time, msg));
  endtask

  task automatic check_rsp(input clkgen_pkg::cfg_rsp_t exp, input clkgen_pkg::cfg_rsp_t got);
    if (got !== exp)
      fail_mismatch($sformatf("response addr %0d data %h, expected addr %0d data %h",
                              got.addr, got.rdata, exp.addr, exp.rdata));
  endtask

  task automatic check_code(input clkgen_pkg::div_code_t exp, input clkgen_pkg::div_code_t got);
    if (got !== exp) fail_mismatch($sformatf("measured code %0d, expected %0d", got, exp));
  endtask

  task automatic check_time(input string what, input realtime exp, input realtime got);
    if (got != exp) fail_mismatch($sformatf("%s %0.3f ns, expected %0.3f ns", what, got, exp));
  endtask

  task automatic check_count(input int exp, input int got);
    if (got != exp) fail_mismatch($sformatf("%0d commands accepted, expected %0d", got, exp));
  endtask

  // Divide rule: period 10 * 2**code ns
  function automatic clkgen_pkg::div_code_t code_from_period(input realtime p);
    for (int i = 0; i <= 6; i++) begin
      if (p == 10.0 * (1 << i)) return clkgen_pkg::div_code_t'(i);
    end
    return 4'hf;
  endfunction

  function automatic realtime half_ns(input clkgen_pkg::div_code_t c);
    if (c == 4'd0) return 5.0;
    if (c >= 4'd8) return 0.0;                // Stopped, no pulse
    return 5.0 * (1 << ((c > 4'd6) ? 6 : c));
  endfunction

  // ##############################
  // Monitors
  // ##############################
  always @(posedge link_clk) begin
    rise_t[0] = $realtime;
    rise_n[0]++;
  end

  always @(posedge link_clk90) begin
    rise_t[1] = $realtime;
    rise_n[1]++;
  end

  always @(posedge core_clk) begin
    rise_t[2] = $realtime;
    rise_n[2]++;
  end

  always @(posedge core_clk90) begin
    rise_t[3] = $realtime;
    rise_n[3]++;
  end

  always @(negedge core_clk) begin
    fall_t[1] = $realtime;
    fall_n[1]++;
  end

  always @(negedge link_clk) begin
    fall_t[0] = $realtime;
    fall_n[0]++;
    if (glitch_min > 0.0 && ($realtime - rise_t[0]) < glitch_min)   // Runt pulse
      fail_mismatch($sformatf("link high pulse %0.3f ns", $realtime - rise_t[0]));
  end

  always @(negedge clkin) begin
    if (!reset && cmd_credit) host_crd++;
    if (!reset && rsp_valid) begin
      rsp_q.push_back(rsp);
      rsp_owed++;
    end
  end

  always @(posedge clkin) begin
    #1;
    if (rsp_owed > 0 && !hold) begin
      rsp_credit = 1'b1;
      rsp_owed--;
    end else begin
      rsp_credit = 1'b0;
    end
  end

  always @(posedge clkin) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: no result after %0d cycles", limit);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  // ##############################
  // Host tasks
  // ##############################
  task automatic send_cmd(input logic wr, input logic [1:0] addr, input clkgen_pkg::div_code_t d);
    while (host_crd == 0) begin
      @(posedge clkin);
      #1;
    end
    cmd_valid = 1'b1;
    cmd       = '{wr: wr, addr: addr, data: d};
    host_crd--;
    @(posedge clkin);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic do_read(input logic [1:0] addr, output clkgen_pkg::cfg_rsp_t r);
    send_cmd(1'b0, addr, 4'd0);
    wait (rsp_q.size() > 0);
    r = rsp_q.pop_front();
    @(posedge clkin);
    #1;
  endtask

  task automatic do_write(input logic [1:0] addr, input clkgen_pkg::div_code_t d);
    clkgen_pkg::cfg_rsp_t r;
    realtime              h_old;
    realtime              h_new;
    if (addr == `CLKGEN_ADDR_LINK) begin
      h_old      = half_ns(cur_link);
      h_new      = half_ns(d);
      glitch_min = (h_old > 0.0 && h_old < h_new) ? h_old : h_new;
      cur_link   = d;
    end
    send_cmd(1'b1, addr, d);
    do begin                                  // Poll until the code is live
      do_read(`CLKGEN_ADDR_STATUS, r);
    end while (r.rdata[addr[0]]);
  endtask

  task automatic measure_clock(input int sel, input clkgen_pkg::div_code_t exp);
    int      idx;
    int      n0;
    int      m0;
    int      f0;
    realtime t1;
    realtime t2;
    realtime per;
    idx = sel * 2;
    n0  = rise_n[idx];
    m0  = rise_n[idx + 1];
    if (exp >= 4'd8) begin
      repeat (20) begin
        @(posedge clkin);
        #1;
        if ((sel == 0) ? link_clk : core_clk) fail_mismatch("stopped clock is high");
        if ((sel == 0) ? link_clk90 : core_clk90)
          fail_mismatch("stopped 90 degree clock is high");
      end
      check_code(exp, (rise_n[idx] == n0 && rise_n[idx + 1] == m0) ? 4'd8 : 4'hf);
    end else begin
      per = 10.0 * (1 << exp);
      wait (rise_n[idx] > n0);
      t1 = rise_t[idx];
      n0 = rise_n[idx];
      wait (rise_n[idx] > n0);
      t2 = rise_t[idx];
      m0 = rise_n[idx + 1];
      f0 = fall_n[sel];
      check_code(exp, code_from_period(t2 - t1));
      wait (fall_n[sel] > f0);
      check_time("high time", per / 2.0, fall_t[sel] - t2);
      if (exp != 4'd0) begin
        wait (rise_n[idx + 1] > m0);
        check_time("90 degree lag", per / 4.0, rise_t[idx + 1] - t2);
      end
      @(posedge clkin);
      #1;
    end
  endtask

  // Alternates reads of addr and status until the host runs dry
  // Then releases credits and checks the order of the responses
  task automatic read_burst(input logic [1:0] addr, input logic [7:0] data, input int exp_n);
    clkgen_pkg::cfg_rsp_t exp;
    clkgen_pkg::cfg_rsp_t exp_q [$];
    int                   sent;
    bit                   stalled;
    sent    = 0;
    stalled = 1'b0;
    hold    = 1'b1;
    while (!stalled) begin
      if (host_crd > 0) begin
        if (sent % 2 == 0) exp = '{addr: addr, rdata: data};
        else exp = '{addr: `CLKGEN_ADDR_STATUS, rdata: 8'h00};  // Nothing pending
        send_cmd(1'b0, exp.addr, 4'd0);
        exp_q.push_back(exp);
        sent++;
      end else begin
        repeat (20) @(posedge clkin);
        #1;
        stalled = host_crd == 0;
      end
    end
    check_count(exp_n, sent);
    hold = 1'b0;
    wait (rsp_q.size() == sent);
    while (rsp_q.size() > 0) check_rsp(exp_q.pop_front(), rsp_q.pop_front());
    @(posedge clkin);
    #1;
  endtask

  // ##############################
  // Main sequence
  // ##############################
  initial begin
    int                   n;
    clkgen_pkg::cfg_rsp_t r;
    clkgen_pkg::cfg_rsp_t exp_rsp;
    $readmemh("bench/clkgen_input.txt", vec);
    n = 0;
    while (n < 64 && vec[n * 4] !== 8'h0f) n++;
    limit = n * 300;
    repeat (3) @(posedge clkin);
    #1;
    reset = 1'b0;
    for (int i = 0; i < n; i++) begin
      case (vec[i * 4])
        8'h0: do_write(vec[i * 4 + 1][1:0], vec[i * 4 + 2][3:0]);
        8'h1: begin
          do_read(vec[i * 4 + 1][1:0], r);
          exp_rsp = '{addr: vec[i * 4 + 1][1:0], rdata: vec[i * 4 + 3]};
          check_rsp(exp_rsp, r);
        end
        8'h2: measure_clock(vec[i * 4 + 1], vec[i * 4 + 3][3:0]);
        8'h3: read_burst(vec[i * 4 + 1][1:0], vec[i * 4 + 2], vec[i * 4 + 3]);
        default: abort_run($sformatf("Unknown vector operation %h on line %0d", vec[i * 4], i));
      endcase
    end
    repeat (5) @(posedge clkin);
    if (i_clkgen_top.u_assert.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Protocol assertions failed %0d times", i_clkgen_top.u_assert.fail_cnt);
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/clkgen_assert.sv ====
// Protocol checks for the link clock generator
// Credit rules on both host channels and low-clock code updates
`timescale 1ns/1ps
`include "clkgen_config.svh"

module clkgen_assert (
  input logic                  clkin,
  input logic                  reset,
  input logic                  cmd_valid,
  input logic                  cmd_credit,
  input logic                  rsp_valid,
  input logic                  rsp_credit,
  input logic                  link_clk,
  input logic                  core_clk,
  input clkgen_pkg::div_code_t link_code,
  input clkgen_pkg::div_code_t core_code
);

  logic [`CLKGEN_CREDIT_W-1:0] host_crd;  // Host view of command credits
  logic [`CLKGEN_CREDIT_W-1:0] dut_crd;   // DUT view of response credits
  int                          fail_cnt = 0;

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      host_crd <= `CLKGEN_CREDIT_W'(`CLKGEN_FIFO_DEPTH);
      dut_crd  <= `CLKGEN_CREDIT_W'(`CLKGEN_FIFO_DEPTH);
    end else begin
      host_crd <= host_crd + `CLKGEN_CREDIT_W'(cmd_credit) - `CLKGEN_CREDIT_W'(cmd_valid);
      dut_crd  <= dut_crd + `CLKGEN_CREDIT_W'(rsp_credit) - `CLKGEN_CREDIT_W'(rsp_valid);
    end
  end

  // ##############################
  // Credit rules
  // ##############################
  a_cmd_credit : assert property (@(posedge clkin) disable iff (reset)
    cmd_valid |-> host_crd != '0)
    else begin fail_cnt++; $error("command sent with no credit"); end

  a_rsp_credit : assert property (@(posedge clkin) disable iff (reset)
    rsp_valid |-> dut_crd != '0)
    else begin fail_cnt++; $error("response sent with no credit"); end

  // ##############################
  // Code moves only on a low clock
  // ##############################
  a_link_low : assert property (@(posedge clkin) disable iff (reset)
    (link_code != $past(link_code)) |-> (!$past(link_clk) || $past(link_code) == '0))
    else begin fail_cnt++; $error("link code changed while clock high"); end

  a_core_low : assert property (@(posedge clkin) disable iff (reset)
    (core_code != $past(core_code)) |-> (!$past(core_clk) || $past(core_code) == '0))
    else begin fail_cnt++; $error("core code changed while clock high"); end

endmodule

bind clkgen_top clkgen_assert u_assert (.*);

// ==== design/clkgen_top.sv ====
// Link clock generator top level
// Host command and response FIFOs, register block and two clock dividers
`timescale 1ns/1ps

module clkgen_top (
  input  logic                 clkin,
  input  logic                 reset,
  input  logic                 cmd_valid,
  input  clkgen_pkg::cfg_cmd_t cmd,
  output logic                 cmd_credit,
  output logic                 rsp_valid,
  output clkgen_pkg::cfg_rsp_t rsp,
  input  logic                 rsp_credit,
  output logic                 link_clk,
  output logic                 link_clk90,
  output logic                 core_clk,
  output logic                 core_clk90
);

  logic                  head_valid;  // Command waiting for decode
  clkgen_pkg::cfg_cmd_t  head_cmd;
  logic                  cmd_pop;
  logic                  rsp_push;
  clkgen_pkg::cfg_rsp_t  rsp_data;
  logic                  rsp_full;
  clkgen_pkg::div_code_t link_code;
  clkgen_pkg::div_code_t core_code;

  // ##############################
  // Host channels
  // ##############################
  credit_fifo #(.payload_t(clkgen_pkg::cfg_cmd_t)) u_cmd_fifo (
    .clkin      (clkin),
    .reset      (reset),
    .in_valid   (cmd_valid),
    .in_data    (cmd),
    .in_credit  (cmd_credit),
    .out_valid  (head_valid),
    .out_data   (head_cmd),
    .out_pop    (cmd_pop),
    .out_credit (1'b1),         // Register block never runs out
    .full       ()
  );

  credit_fifo #(.payload_t(clkgen_pkg::cfg_rsp_t)) u_rsp_fifo (
    .clkin      (clkin),
    .reset      (reset),
    .in_valid   (rsp_push),
    .in_data    (rsp_data),
    .in_credit  (),
    .out_valid  (rsp_valid),
    .out_data   (rsp),
    .out_pop    (1'b1),         // Host takes every response sent
    .out_credit (rsp_credit),
    .full       (rsp_full)
  );

  clkgen_regs u_regs (
    .clkin     (clkin),
    .reset     (reset),
    .cmd_valid (head_valid),
    .cmd       (head_cmd),
    .cmd_pop   (cmd_pop),
    .rsp_push  (rsp_push),
    .rsp       (rsp_data),
    .rsp_full  (rsp_full),
    .link_clk  (link_clk),
    .core_clk  (core_clk),
    .link_code (link_code),
    .core_code (core_code)
  );

  // ##############################
  // Dividers
  // ##############################
  clock_divider u_link_div (
    .clkin    (clkin),
    .reset    (reset),
    .divcfg   (link_code),
    .clkout   (link_clk),
    .clkout90 (link_clk90)
  );

  clock_divider u_core_div (
    .clkin    (clkin),
    .reset    (reset),
    .divcfg   (core_code),
    .clkout   (core_clk),
    .clkout90 (core_clk90)
  );

endmodule

// ==== design/clock_divider.sv ====
// Programmable clock divider with a phase-aligned and a 90 degree output
// A new code takes effect at the next period boundary, code 0 passes clkin
`timescale 1ns/1ps

module clock_divider (
  input  logic                  clkin,
  input  logic                  reset,
  input  clkgen_pkg::div_code_t divcfg,
  output logic                  clkout,
  output logic                  clkout90
);

  logic [6:0] dec;         // One-hot divide of requested code
  logic [6:0] dec_q;       // Divide of the running period, 0 when idle
  logic [6:0] cnt;         // Runs 1 to N
  logic       idle;
  logic       div2_sel;
  logic       full_match;
  logic       half_match;
  logic       q_match;
  logic       tq_match;
  logic       clk_reg;
  logic       c90_pos;     // 90 degree phase for N of 4 and up
  logic       c90_neg;     // 90 degree phase for N of 2
  logic       bypass_q;

  // ##############################
  // Code decode
  // ##############################
  always_comb begin
    case (divcfg)
      4'd1:       dec = 7'b0000010;
      4'd2:       dec = 7'b0000100;
      4'd3:       dec = 7'b0001000;
      4'd4:       dec = 7'b0010000;
      4'd5:       dec = 7'b0100000;
      4'd6, 4'd7: dec = 7'b1000000;  // 7 saturates at 64
      default:    dec = 7'b0000000;  // Bypass or stopped
    endcase
  end

  assign idle       = dec_q == '0;
  assign div2_sel   = dec_q == 7'd2;
  assign full_match = cnt == dec_q;
  assign half_match = cnt == {1'b0, dec_q[6:1]};
  assign q_match    = cnt == {2'b00, dec_q[6:2]};
  assign tq_match   = cnt == ({2'b00, dec_q[6:2]} + {1'b0, dec_q[6:1]});

  // ##############################
  // Counter and main phase
  // ##############################
  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      dec_q   <= '0;
      cnt     <= 7'd1;
      clk_reg <= 1'b0;
    end else if (idle) begin
      dec_q   <= dec;              // Leave idle at once, low for N cycles
      cnt     <= 7'd1;
      clk_reg <= 1'b0;
    end else if (full_match) begin
      dec_q   <= dec;              // Whole periods only, no runt
      cnt     <= 7'd1;             // Self resetting
      clk_reg <= dec != '0;        // Stays low when stopping
    end else begin
      cnt <= cnt + 7'd1;
      if (half_match) clk_reg <= 1'b0;
    end
  end

  // ##############################
  // Quadrature phase
  // ##############################
  always_ff @(posedge clkin or posedge reset) begin
    if (reset) c90_pos <= 1'b0;
    else if (idle || div2_sel) c90_pos <= 1'b0;
    else if (q_match) c90_pos <= 1'b1;    // N/4 after rise
    else if (tq_match) c90_pos <= 1'b0;   // 3N/4 after rise
  end

  // Half a clkin cycle behind clk_reg at divide by 2
  always_ff @(negedge clkin or posedge reset) begin
    if (reset) c90_neg <= 1'b0;
    else if (!div2_sel) c90_neg <= 1'b0;
    else if (half_match) c90_neg <= 1'b1;
    else if (full_match) c90_neg <= 1'b0;
  end

  // Bypass select moves only while clkin is low
  always_ff @(negedge clkin or posedge reset) begin
    if (reset) bypass_q <= 1'b0;
    else bypass_q <= divcfg == '0;
  end

  assign clkout   = bypass_q ? clkin : clk_reg;
  assign clkout90 = c90_pos | c90_neg;    // Never both high

endmodule

// ==== design/clkgen_regs.sv ====
// Configuration registers of the link clock generator
// Decodes host commands, answers reads, moves codes to the dividers while low
`timescale 1ns/1ps
`include "clkgen_config.svh"

module clkgen_regs (
  input  logic                  clkin,
  input  logic                  reset,
  input  logic                  cmd_valid,   // Head of command FIFO
  input  clkgen_pkg::cfg_cmd_t  cmd,
  output logic                  cmd_pop,
  output logic                  rsp_push,
  output clkgen_pkg::cfg_rsp_t  rsp,
  input  logic                  rsp_full,
  input  logic                  link_clk,    // Divider outputs fed back
  input  logic                  core_clk,
  output clkgen_pkg::div_code_t link_code,
  output clkgen_pkg::div_code_t core_code
);

  clkgen_pkg::div_state_t link_st;
  clkgen_pkg::div_state_t core_st;
  clkgen_pkg::div_code_t  link_shadow;  // Last written code
  clkgen_pkg::div_code_t  core_shadow;
  logic                   wr_link;
  logic                   wr_core;

  // Pending code goes active once the clock is low
  // Bypass retimes itself on the falling edge inside the divider
  function automatic clkgen_pkg::div_state_t apply_code(
    input clkgen_pkg::div_state_t st,
    input clkgen_pkg::div_code_t  shadow,
    input logic                   clk
  );
    clkgen_pkg::div_state_t nxt;
    nxt = st;
    if (st.pending && (!clk || st.code == '0)) begin
      nxt.code    = shadow;
      nxt.pending = 1'b0;
    end
    return nxt;
  endfunction

  // ##############################
  // Command decode
  // ##############################
  assign cmd_pop  = cmd_valid && !(!cmd.wr && rsp_full);  // Reads wait for a free slot
  assign rsp_push = cmd_pop && !cmd.wr;
  assign wr_link  = cmd_pop && cmd.wr && (cmd.addr == `CLKGEN_ADDR_LINK);
  assign wr_core  = cmd_pop && cmd.wr && (cmd.addr == `CLKGEN_ADDR_CORE);

  always_comb begin
    rsp.addr  = cmd.addr;
    rsp.rdata = '0;                                         // Unmapped reads as 0
    case (cmd.addr)
      `CLKGEN_ADDR_LINK:   rsp.rdata = {4'h0, link_st.code};
      `CLKGEN_ADDR_CORE:   rsp.rdata = {4'h0, core_st.code};
      `CLKGEN_ADDR_STATUS: rsp.rdata = {6'h00, core_st.pending, link_st.pending};
      default:             ;
    endcase
  end

  // ##############################
  // Shadow and active codes
  // ##############################
  always_ff @(posedge clkin) begin
    if (wr_link) link_shadow <= cmd.data;
    if (wr_core) core_shadow <= cmd.data;
  end

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      link_st <= '{code: 4'd8, pending: 1'b0};              // Stopped
      core_st <= '{code: 4'd8, pending: 1'b0};
    end else begin
      link_st <= apply_code(link_st, link_shadow, link_clk);
      core_st <= apply_code(core_st, core_shadow, core_clk);
      if (wr_link) link_st.pending <= 1'b1;                 // New write wins over update
      if (wr_core) core_st.pending <= 1'b1;
    end
  end

  assign link_code = link_st.code;
  assign core_code = core_st.code;

endmodule

// ==== design/credit_fifo.sv ====
// Credit-based FIFO for one channel of the host link
// Returns one input credit per pop, sends out only while output credit remains
`timescale 1ns/1ps
`include "clkgen_config.svh"

module credit_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clkin,
  input  logic     reset,
  input  logic     in_valid,    // Sender push, one credit spent
  input  payload_t in_data,
  output logic     in_credit,   // One pulse per freed slot
  output logic     out_valid,   // Head entry present and credit left
  output payload_t out_data,
  input  logic     out_pop,     // Sink takes the head entry
  input  logic     out_credit,  // Credit back from the sink
  output logic     full
);

  localparam int PTR_W = $clog2(`CLKGEN_FIFO_DEPTH);
  localparam logic [`CLKGEN_CREDIT_W-1:0] DEPTH_C = `CLKGEN_CREDIT_W'(`CLKGEN_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`CLKGEN_FIFO_DEPTH - 1);

  payload_t                   mem [`CLKGEN_FIFO_DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [`CLKGEN_CREDIT_W-1:0] count;    // Occupancy
  logic [`CLKGEN_CREDIT_W-1:0] crd_cnt;  // Output credits held
  logic                       push;
  logic                       pop;

  assign full      = count == DEPTH_C;
  assign push      = in_valid && !full;                       // Drop only on protocol error
  assign out_valid = (count != '0) && (crd_cnt != '0);
  assign out_data  = mem[rd_ptr];
  assign pop       = out_valid && out_pop;
  assign in_credit = pop;                                     // Same cycle as the pop

  always_ff @(posedge clkin) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      crd_cnt <= DEPTH_C;                                     // Sink starts with all slots
    end else begin
      if (push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                                            // Both or neither
      endcase
      case ({out_credit, pop})
        2'b10:   if (crd_cnt != DEPTH_C) crd_cnt <= crd_cnt + 1'b1;  // Saturate when tied high
        2'b01:   crd_cnt <= crd_cnt - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== design/clkgen_pkg.sv ====
// Shared types for the link clock generator
// Host commands, read responses and per-divider state
package clkgen_pkg;

  // 0 bypass, 1..6 divide by 2**code, 7 divide by 64, 8..15 stopped
  typedef logic [3:0] div_code_t;

  // One host command
  typedef struct packed {
    logic       wr;    // 1 write, 0 read
    logic [1:0] addr;  // Register address
    div_code_t  data;  // Write data, unused on reads
  } cfg_cmd_t;

  // One read response
  typedef struct packed {
    logic [1:0] addr;   // Echo of the read address
    logic [7:0] rdata;  // Zero extended register value
  } cfg_rsp_t;

  // Per-divider state in the register block
  typedef struct packed {
    div_code_t code;     // Code seen by the divider
    logic      pending;  // Shadow code waiting for a low clock
  } div_state_t;

endpackage

// ==== design/clkgen_config.svh ====
// Link clock generator configuration
// FIFO sizing, credit width and register map
`ifndef CLKGEN_CONFIG_SVH
`define CLKGEN_CONFIG_SVH

// ##############################
// Credit channels
// ##############################
`define CLKGEN_FIFO_DEPTH 4   // Entries per FIFO, also initial credits
`define CLKGEN_CREDIT_W   3   // Holds 0 to FIFO depth

// ##############################
// Register map
// ##############################
`define CLKGEN_ADDR_LINK   2'd0  // Link clock divide code
`define CLKGEN_ADDR_CORE   2'd1  // Core clock divide code
`define CLKGEN_ADDR_STATUS 2'd2  // Pending flags, core in bit 1

`endif
